// File: Makefile
# Verilator build and run for the cache store testbench

TOP = cache_store_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 \
		-f cache_store.f \
		--top-module $(TOP) \
		-o $(TOP)

# Assertion errors do not stop the run, so the testbench prints its verdict
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "NO ERRORS" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: cache_store.f
design/cache_pkg.sv
design/bank_ram.sv
design/memory_bank.sv
design/tag_store.sv
design/hit_merge.sv
design/cache_store_top.sv
sim/cache_store_assert.sv
sim/cache_store_tb.sv

// File: design/bank_ram.sv
`timescale 1ns/100ps

// One byte-wide bank, simple dual port
module bank_ram
	import cache_pkg::*;
#(
	parameter int DEPTH_BITS = 6
)
(
	input  logic                  CLK,
	input  logic                  wr_en,
	input  logic [DEPTH_BITS-1:0] wr_addr,
	input  byte_t                 wr_data,
	input  logic                  rd_en,
	input  logic [DEPTH_BITS-1:0] rd_addr,
	output byte_t                 rd_data
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	byte_t mem [DEPTH]; // Storage, no reset

	// Write port
	always_ff @(posedge CLK)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read, holds while idle
	// Same-address collision returns the old byte
	always_ff @(posedge CLK)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

// File: design/cache_pkg.sv
package cache_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Line geometry
	////////////////////////////////////////////////////////////////////////////

	// Byte offset inside a line, also the bank select
	localparam int OFFSET_BITS = 3;

	// One byte bank per offset, so one line is NUM_BANKS bytes
	localparam int NUM_BANKS = 1 << OFFSET_BITS;

	////////////////////////////////////////////////////////////////////////////
	// Payload types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [7:0] byte_t;

	typedef byte_t [NUM_BANKS-1:0] line_t; // Byte 0 in the low bits

	typedef logic [NUM_BANKS-1:0] mask_t; // One valid bit per byte

endpackage

// File: design/cache_store_top.sv
`timescale 1ns/100ps

// Cache data store, two-cycle lookup latency
module cache_store_top
	import cache_pkg::*;
#(
	parameter int ADDR_BITS  = 14,
	parameter int INDEX_BITS = 6
)
(
	input  logic                 CLK,
	input  logic                 rst_n,
	input  logic                 wr_req,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  byte_t                wr_data,
	input  logic                 rd_req,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output logic                 rd_valid,
	output logic                 rd_hit,
	output logic                 rd_full,
	output byte_t                rd_byte,
	output line_t                rd_line
);

	////////////////////////////////////////////////////////////////////////////
	// Address slices and internal wires
	////////////////////////////////////////////////////////////////////////////

	logic [INDEX_BITS-1:0]             rd_index;
	logic [INDEX_BITS+OFFSET_BITS-1:0] wr_low;      // Index and offset, tag dropped

	line_t                  line_data;
	logic                   look_valid;
	logic                   tag_match;
	mask_t                  valid_mask;
	logic [OFFSET_BITS-1:0] look_offset;

	assign rd_index = rd_addr[INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS];
	assign wr_low   = wr_addr[INDEX_BITS+OFFSET_BITS-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////

	memory_bank #(
		.ADDR_BITS  (ADDR_BITS),
		.INDEX_BITS (INDEX_BITS)
	) memory_bank_i (
		.CLK       (CLK),
		.rd_req    (rd_req),
		.rd_index  (rd_index),
		.wr_req    (wr_req),
		.wr_addr   (wr_low),
		.wr_data   (wr_data),
		.line_data (line_data)
	);

	tag_store #(
		.ADDR_BITS  (ADDR_BITS),
		.INDEX_BITS (INDEX_BITS)
	) tag_store_i (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.look_valid  (look_valid),
		.tag_match   (tag_match),
		.valid_mask  (valid_mask),
		.look_offset (look_offset)
	);

	hit_merge hit_merge_i (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.look_valid  (look_valid),
		.tag_match   (tag_match),
		.valid_mask  (valid_mask),
		.look_offset (look_offset),
		.line_data   (line_data),
		.rd_valid    (rd_valid),
		.rd_hit      (rd_hit),
		.rd_full     (rd_full),
		.rd_byte     (rd_byte),
		.rd_line     (rd_line)
	);

endmodule

// File: design/hit_merge.sv
`timescale 1ns/100ps

// Tag result plus line data into the registered read result
module hit_merge
	import cache_pkg::*;
(
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   look_valid,
	input  logic                   tag_match,
	input  mask_t                  valid_mask,
	input  logic [OFFSET_BITS-1:0] look_offset,
	input  line_t                  line_data,
	output logic                   rd_valid,
	output logic                   rd_hit,
	output logic                   rd_full,
	output byte_t                  rd_byte,
	output line_t                  rd_line
);

	logic byte_hit;
	logic line_full;

	// Tag must match and the byte must have been filled
	assign byte_hit  = tag_match & valid_mask[look_offset];
	assign line_full = tag_match & (&valid_mask); // All eight bytes present

	// Flags, cleared by reset
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			rd_valid <= 1'b0;
			rd_hit   <= 1'b0;
			rd_full  <= 1'b0;
		end
		else
		begin
			rd_valid <= look_valid; // One pulse per lookup
			if (look_valid)
			begin
				rd_hit  <= byte_hit;
				rd_full <= line_full;
			end
		end
	end

	// Data path, loaded with each lookup result
	always_ff @(posedge CLK)
	begin
		if (look_valid)
		begin
			rd_byte <= line_data[look_offset]; // Offset picks the byte
			rd_line <= line_data;
		end
	end

endmodule

// File: design/memory_bank.sv
`timescale 1ns/100ps

// Eight interleaved byte banks
// Fill writes one bank, lookup bursts the whole line
module memory_bank
	import cache_pkg::*;
#(
	parameter int ADDR_BITS  = 14,
	parameter int INDEX_BITS = 6
)
(
	input  logic                              CLK,
	input  logic                              rd_req,
	input  logic [INDEX_BITS-1:0]             rd_index,
	input  logic                              wr_req,
	input  logic [INDEX_BITS+OFFSET_BITS-1:0] wr_addr,
	input  byte_t                             wr_data,
	output line_t                             line_data
);

	logic [INDEX_BITS-1:0]  wr_index;
	logic [OFFSET_BITS-1:0] wr_offset;
	mask_t                  wr_sel; // One-hot bank write enable

	// Address must leave room for a tag above index and offset
	if (ADDR_BITS <= INDEX_BITS + OFFSET_BITS)
	begin : g_addr_check
		$error("memory_bank: ADDR_BITS too small for index and offset");
	end

	assign wr_index  = wr_addr[INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS];
	assign wr_offset = wr_addr[OFFSET_BITS-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Write bank select
	////////////////////////////////////////////////////////////////////////////

	// Combinational so the byte lands at the strobe edge
	always_comb
	begin
		wr_sel = '0;
		if (wr_req)
			wr_sel[wr_offset] = 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Banks
	////////////////////////////////////////////////////////////////////////////

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		bank_ram #(
			.DEPTH_BITS (INDEX_BITS)
		) bank_ram_i (
			.CLK     (CLK),
			.wr_en   (wr_sel[b]),   // Only the addressed bank
			.wr_addr (wr_index),
			.wr_data (wr_data),     // Same byte offered to every bank
			.rd_en   (rd_req),      // All banks on a lookup
			.rd_addr (rd_index),
			.rd_data (line_data[b]) // Joined in bank order
		);
	end

endmodule

// File: design/tag_store.sv
`timescale 1ns/100ps

// Direct-mapped tag and per-byte valid mask, one entry per line
module tag_store
	import cache_pkg::*;
#(
	parameter int ADDR_BITS  = 14,
	parameter int INDEX_BITS = 6
)
(
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   wr_req,
	input  logic [ADDR_BITS-1:0]   wr_addr,
	input  logic                   rd_req,
	input  logic [ADDR_BITS-1:0]   rd_addr,
	output logic                   look_valid,
	output logic                   tag_match,
	output mask_t                  valid_mask,
	output logic [OFFSET_BITS-1:0] look_offset
);

	localparam int TAG_BITS  = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
	localparam int NUM_LINES = 1 << INDEX_BITS;

	logic [TAG_BITS-1:0] tag_mem  [NUM_LINES]; // Flops, one-cycle update on fill
	mask_t               mask_mem [NUM_LINES];

	// Address split, tag on top
	logic [TAG_BITS-1:0]    wr_tag;
	logic [INDEX_BITS-1:0]  wr_index;
	logic [OFFSET_BITS-1:0] wr_offset;
	logic [TAG_BITS-1:0]    rd_tag;
	logic [INDEX_BITS-1:0]  rd_index;

	logic  evict;
	mask_t fill_bit;
	mask_t next_mask;

	assign {wr_tag, wr_index, wr_offset} = wr_addr;
	assign rd_tag   = rd_addr[ADDR_BITS-1:INDEX_BITS+OFFSET_BITS];
	assign rd_index = rd_addr[INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS];

	////////////////////////////////////////////////////////////////////////////
	// Fill update
	////////////////////////////////////////////////////////////////////////////

	assign fill_bit = mask_t'(1) << wr_offset;

	// New tag or empty line starts over with just this byte
	assign evict     = (tag_mem[wr_index] != wr_tag) || (mask_mem[wr_index] == '0);
	assign next_mask = evict ? fill_bit : (mask_mem[wr_index] | fill_bit);

	always_ff @(posedge CLK)
	begin
		if (wr_req)
			tag_mem[wr_index] <= wr_tag; // Unchanged unless evicting
	end

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_LINES; i++)
				mask_mem[i] <= '0; // Every line empty
		end
		else if (wr_req)
			mask_mem[wr_index] <= next_mask;
	end

	////////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////////

	// One-cycle strobe
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
			look_valid <= 1'b0;
		else
			look_valid <= rd_req;
	end

	// Samples the entry before any same-edge fill, i.e. read-first
	always_ff @(posedge CLK)
	begin
		if (rd_req)
		begin
			tag_match   <= (tag_mem[rd_index] == rd_tag);
			valid_mask  <= mask_mem[rd_index];
			look_offset <= rd_addr[OFFSET_BITS-1:0];
		end
	end

endmodule

// File: sim/cache_store_assert.sv
`timescale 1ns/100ps

// Port-level protocol checks on the cache store
module cache_store_assert
(
	input logic CLK,
	input logic rst_n,
	input logic rd_req,
	input logic rd_valid,
	input logic rd_hit,
	input logic rd_full
);

	logic in_reset_d; // Reset seen at the previous edge
	int   n_fail = 0; // Count of failed assertions

	always @(posedge CLK)
	begin
		in_reset_d <= !rst_n;
	end

	////////////////////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////////////////////

	// Fixed two-cycle lookup latency
	valid_latency: assert property (@(posedge CLK) disable iff (!rst_n)
		rd_valid == $past(rd_req, 2))
	else
	begin
		$error("rd_valid does not follow rd_req by two cycles");
		n_fail++;
	end

	// A full line always covers the requested byte
	full_has_hit: assert property (@(posedge CLK) disable iff (!rst_n) rd_full |-> rd_hit)
	else
	begin
		$error("rd_full high without rd_hit");
		n_fail++;
	end

	quiet_in_reset: assert property (@(posedge CLK) (!rst_n && in_reset_d) |-> !rd_valid)
	else
	begin
		$error("rd_valid high during reset");
		n_fail++;
	end

endmodule

bind cache_store_top cache_store_assert cache_store_assert_i (
	.CLK      (CLK),
	.rst_n    (rst_n),
	.rd_req   (rd_req),
	.rd_valid (rd_valid),
	.rd_hit   (rd_hit),
	.rd_full  (rd_full)
);

// File: sim/cache_store_tb.sv
`timescale 1ns/100ps

// Testbench for the cache data store
module cache_store_tb
	import cache_pkg::*;
;

	localparam int ADDR_BITS  = 14;
	localparam int INDEX_BITS = 6;
	localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
	localparam int NUM_LINES  = 1 << INDEX_BITS;
	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS   = 26;  // Directed table length
	localparam int NUM_RAND   = 200; // LFSR-driven operations
	localparam int EXP_DEPTH  = NUM_ROWS + NUM_RAND;
	localparam int WATCH_NS   = (NUM_ROWS + NUM_RAND + 20) * CLK_PERIOD * 2;
	localparam logic [31:0] LFSR_SEED = 32'hc502;

	localparam logic [1:0] OP_WR   = 2'b01; // Bit 0 fill, bit 1 lookup
	localparam logic [1:0] OP_RD   = 2'b10;
	localparam logic [1:0] OP_BOTH = 2'b11;

	typedef logic [ADDR_BITS-1:0] addr_t;

	typedef struct packed {
		logic  hit;
		byte_t data;
		logic  full;
		line_t line;
	} exp_t;

	typedef struct packed {
		logic [1:0] op;
		addr_t      wa;
		byte_t      wd;
		addr_t      ra;
		exp_t       exp_v;
	} row_t;

	logic  CLK = 1'b0;
	logic  rst_n;
	logic  wr_req;
	addr_t wr_addr;
	byte_t wr_data;
	logic  rd_req;
	addr_t rd_addr;
	logic  rd_valid;
	logic  rd_hit;
	logic  rd_full;
	byte_t rd_byte;
	line_t rd_line;

	row_t  stim [NUM_ROWS];
	int    n_rows = 0;
	exp_t  exp_mem [EXP_DEPTH]; // Pending lookups with the oldest at rd_ptr
	int    wr_ptr = 0;
	int    rd_ptr = 0;
	exp_t  mon_e;
	int    n_checks = 0;
	int    n_errors = 0;
	logic [31:0] lfsr = LFSR_SEED;

	// Reference model of the store
	logic [TAG_BITS-1:0] tag_m  [NUM_LINES];
	mask_t               mask_m [NUM_LINES];
	line_t               data_m [NUM_LINES];

	cache_store_top #(
		.ADDR_BITS  (ADDR_BITS),
		.INDEX_BITS (INDEX_BITS)
	) cache_store_top_i (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.wr_req   (wr_req),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_valid (rd_valid),
		.rd_hit   (rd_hit),
		.rd_full  (rd_full),
		.rd_byte  (rd_byte),
		.rd_line  (rd_line)
	);

	always #(CLK_PERIOD/2) CLK = ~CLK; // 40 ns period

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic addr_t mk_addr(input int tag, input int idx, input int off);
		return {tag[TAG_BITS-1:0], idx[INDEX_BITS-1:0], off[OFFSET_BITS-1:0]};
	endfunction

	// Galois LFSR stepped once per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        out;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			out  = lfsr[0];
			lfsr = lfsr >> 1;
			if (out)
				lfsr = lfsr ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
			v = {v[30:0], out};
		end
		return v;
	endfunction

	// Lookup result as the store holds it now
	function automatic exp_t model_read(input addr_t a);
		exp_t                   e;
		logic [TAG_BITS-1:0]    t;
		logic [INDEX_BITS-1:0]  i;
		logic [OFFSET_BITS-1:0] o;
		{t, i, o} = a;
		e.hit  = (tag_m[i] == t) && mask_m[i][o];
		e.full = (tag_m[i] == t) && (mask_m[i] == '1);
		e.data = data_m[i][o];
		e.line = data_m[i];
		return e;
	endfunction

	task automatic model_write(input addr_t a, input byte_t d);
		logic [TAG_BITS-1:0]    t;
		logic [INDEX_BITS-1:0]  i;
		logic [OFFSET_BITS-1:0] o;
		{t, i, o} = a;
		if (tag_m[i] != t || mask_m[i] == '0)
		begin
			tag_m[i]  = t;  // Eviction starts the line over
			mask_m[i] = '0;
		end
		mask_m[i][o] = 1'b1;
		data_m[i][o] = d;
	endtask

	task automatic add_row(input logic [1:0] op, input addr_t wa, input byte_t wd,
		input addr_t ra, input logic hit, input byte_t b, input logic full, input line_t line);
		stim[n_rows] = {op, wa, wd, ra, hit, b, full, line};
		n_rows++;
	endtask

	// One operation per cycle with the expectation queued before the model sees the fill
	task automatic drive(input logic [1:0] op, input addr_t wa, input byte_t wd,
		input addr_t ra, input exp_t e);
		@(posedge CLK);
		wr_req  <= op[0];
		wr_addr <= wa;
		wr_data <= wd;
		rd_req  <= op[1];
		rd_addr <= ra;
		if (op[1])
		begin
			exp_mem[wr_ptr] = e;
			wr_ptr++;
		end
		if (op[0])
			model_write(wa, wd);
	endtask

	task automatic go_idle();
		@(posedge CLK);
		wr_req <= 1'b0;
		rd_req <= 1'b0;
	endtask

	task automatic wait_drain();
		while (rd_ptr != wr_ptr)
			@(posedge CLK);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		add_row(OP_RD, '0, 8'h00, mk_addr(1, 2, 0), 1'b0, 8'h00, 1'b0, '0); // Empty store
		add_row(OP_WR, mk_addr(1, 2, 3), 8'h33, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(1, 2, 3), 1'b1, 8'h33, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(1, 2, 4), 1'b0, 8'h00, 1'b0, '0); // Unfilled byte
		add_row(OP_WR, mk_addr(1, 2, 0), 8'h30, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_WR, mk_addr(1, 2, 1), 8'h31, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_WR, mk_addr(1, 2, 2), 8'h32, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_WR, mk_addr(1, 2, 4), 8'h34, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_WR, mk_addr(1, 2, 5), 8'h35, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_WR, mk_addr(1, 2, 6), 8'h36, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_WR, mk_addr(1, 2, 7), 8'h37, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(1, 2, 5), 1'b1, 8'h35, 1'b1,
			64'h3736_3534_3332_3130); // Whole line in offset order
		add_row(OP_WR, mk_addr(2, 2, 1), 8'ha1, '0, 1'b0, 8'h00, 1'b0, '0); // Evicts tag 1
		add_row(OP_RD, '0, 8'h00, mk_addr(1, 2, 0), 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(2, 2, 1), 1'b1, 8'ha1, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(2, 2, 0), 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_BOTH, mk_addr(2, 2, 2), 8'ha2, mk_addr(2, 2, 2), 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(2, 2, 2), 1'b1, 8'ha2, 1'b0, '0);
		add_row(OP_BOTH, mk_addr(2, 2, 1), 8'hb1, mk_addr(2, 2, 1), 1'b1, 8'ha1, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(2, 2, 1), 1'b1, 8'hb1, 1'b0, '0);
		add_row(OP_BOTH, mk_addr(3, 2, 2), 8'hc2, mk_addr(2, 2, 2), 1'b1, 8'ha2, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(2, 2, 2), 1'b0, 8'h00, 1'b0, '0); // Old tag gone
		add_row(OP_RD, '0, 8'h00, mk_addr(3, 2, 2), 1'b1, 8'hc2, 1'b0, '0);
		add_row(OP_WR, mk_addr(1, 5, 7), 8'h57, '0, 1'b0, 8'h00, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(1, 5, 7), 1'b1, 8'h57, 1'b0, '0);
		add_row(OP_RD, '0, 8'h00, mk_addr(1, 2, 7), 1'b0, 8'h00, 1'b0, '0);
	endtask

	task automatic run_table();
		for (int k = 0; k < NUM_ROWS; k++)
			drive(stim[k].op, stim[k].wa, stim[k].wd, stim[k].ra, stim[k].exp_v);
		go_idle();
	endtask

	// Mixed traffic over lines 8 and 9 with two tags each
	task automatic run_random();
		logic [31:0] op_r;
		logic [31:0] wt;
		logic [31:0] wi;
		logic [31:0] wo;
		logic [31:0] wd_r;
		logic [31:0] rt;
		logic [31:0] ri;
		logic [31:0] ro;
		addr_t       wa;
		addr_t       ra;
		exp_t        e;
		for (int k = 0; k < NUM_RAND; k++)
		begin
			op_r = take_bits(2); // 0 idle, 1 fill, 2 lookup, 3 both
			wt   = take_bits(1);
			wi   = take_bits(1);
			wo   = take_bits(3);
			wd_r = take_bits(8);
			rt   = take_bits(1);
			ri   = take_bits(1);
			ro   = take_bits(3);
			wa   = mk_addr(wt, 8 + wi, wo);
			ra   = mk_addr(rt, 8 + ri, ro);
			e    = model_read(ra); // Taken before the fill as the store reads first
			drive(op_r[1:0], wa, wd_r[7:0], ra, e);
		end
		go_idle();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Response monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK)
	begin
		if (rst_n === 1'b1)
		begin
			if (rd_valid === 1'b1)
			begin
				if (rd_ptr == wr_ptr)
				begin
					$display("%0t: rd_valid went high with no lookup pending", $time);
					n_errors++;
				end
				else
				begin
					mon_e = exp_mem[rd_ptr];
					n_checks++;
					if (rd_hit !== mon_e.hit)
					begin
						$display("ERR %0t rd_hit expected %0b got %0b", $time, mon_e.hit, rd_hit);
						n_errors++;
					end
					if (rd_full !== mon_e.full)
					begin
						$display("ERR %0t rd_full expected %0b got %0b", $time, mon_e.full, rd_full);
						n_errors++;
					end
					if (mon_e.hit && rd_byte !== mon_e.data) // Byte only counts on a hit
					begin
						$display("ERR %0t rd_byte expected %h got %h", $time, mon_e.data, rd_byte);
						n_errors++;
					end
					if (mon_e.full && rd_line !== mon_e.line)
					begin
						$display("ERR %0t rd_line expected %h got %h", $time, mon_e.line, rd_line);
						n_errors++;
					end
					rd_ptr++;
				end
			end
			else if (rd_valid !== 1'b0)
			begin
				$display("ERR %0t rd_valid expected 0 got %b", $time, rd_valid);
				n_errors++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int chk0;
		int err0;
		int n_assert;
		rst_n   = 1'b0;
		wr_req  = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_req  = 1'b0;
		rd_addr = '0;
		for (int i = 0; i < NUM_LINES; i++)
		begin
			tag_m[i]  = '0;
			mask_m[i] = '0;
			data_m[i] = '0;
		end
		build_table();
		repeat (8) @(posedge CLK);
		rst_n <= 1'b1;

		err0 = n_errors;
		repeat (4) @(posedge CLK); // rd_valid must stay quiet
		$display("test reset: rd_valid idle after reset, %0d errors", n_errors - err0);

		chk0 = n_checks;
		err0 = n_errors;
		run_table();
		wait_drain();
		$display("test table: %0d lookups checked, %0d errors", n_checks - chk0, n_errors - err0);

		chk0 = n_checks;
		err0 = n_errors;
		run_random();
		wait_drain();
		$display("test random: %0d lookups checked, %0d errors", n_checks - chk0, n_errors - err0);

		repeat (2) @(posedge CLK);
		n_assert = cache_store_top_i.cache_store_assert_i.n_fail; // Bound checker
		n_errors += n_assert;
		$display("total: %0d lookups checked, %0d assertion failures, %0d errors",
			n_checks, n_assert, n_errors);
		if (n_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog sized from the table and random lengths
	initial
	begin
		#(WATCH_NS);
		$display("Timeout: run did not finish within %0d ns", WATCH_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule
